// File: rtl/cache_pkg.sv
// Shared geometry, address split, entry types and LFSR seed for the cache tag subsystem
`default_nettype none

package cache_pkg;

    // ----------------------------------------------------------------------
    // Address layout
    // ----------------------------------------------------------------------
    localparam int unsigned ADDR_W   = 32;
    // Byte offset inside one line
    localparam int unsigned OFFSET_W = 4;
    // Set index sits just above the offset
    localparam int unsigned INDEX_W  = 4;
    // Everything above offset and index is tag
    localparam int unsigned TAG_W    = ADDR_W - OFFSET_W - INDEX_W;

    // ----------------------------------------------------------------------
    // Cache geometry
    // ----------------------------------------------------------------------
    localparam int unsigned NUM_SETS   = 1 << INDEX_W;
    localparam int unsigned NUM_WAYS   = 4;
    localparam int unsigned WAY_W      = $clog2(NUM_WAYS);

    // Miss queue depth and its pointer and count widths
    localparam int unsigned MISS_DEPTH = 4;
    localparam int unsigned MISS_PTR_W = $clog2(MISS_DEPTH);
    localparam int unsigned MISS_CNT_W = $clog2(MISS_DEPTH + 1);

    // Replacement LFSR state after reset, must not be all ones
    localparam logic [15:0] LFSR_SEED  = 16'hACE1;

    // One outstanding miss: which set and which line
    typedef struct packed {
        logic [INDEX_W-1:0] index;
        logic [TAG_W-1:0]   tag;
    } miss_entry_t;

    // One way of one set in the tag store
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

endpackage

`default_nettype wire

// File: rtl/miss_if.sv
// Miss entry path from the lookup stage into the miss queue, one strobe per miss
`default_nettype none

interface miss_if import cache_pkg::*; ();

    // Strobe, one entry taken per high cycle
    logic        push;
    // Set and tag of the missed line
    miss_entry_t entry;
    // Queue level, no push allowed while high
    logic        full;

    // Producer side, lookup stage
    modport tag_lookup (
        output push,
        output entry,
        input  full
    );

    // Consumer side, miss queue
    modport miss_fifo (
        input  push,
        input  entry,
        output full
    );

endinterface

`default_nettype wire

// File: rtl/lfsr_16bit.sv
// Pseudo-random victim way selector, steps on enable and names a way one-hot and binary
`default_nettype none

module lfsr_16bit #(
    parameter logic [15:0] SEED  = 16'h0001,
    parameter int unsigned WIDTH = 16
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     en,
    output logic [WIDTH-1:0]         refill_way_oh,
    output logic [$clog2(WIDTH)-1:0] refill_way_bin
);

    // ----------------------------------------------------------------------
    // Shift register
    // ----------------------------------------------------------------------
    logic [15:0] state_q;
    logic [15:0] state_d;
    logic        feedback;

    // Inverted XOR of taps 15, 12, 5 and 1
    // All ones is the lockup state with this feedback
    assign feedback = ~(state_q[15] ^ state_q[12] ^ state_q[5] ^ state_q[1]);

    always_comb begin
        state_d = state_q;
        // Shift left, new bit enters at the bottom
        if (en) begin
            state_d = {state_q[14:0], feedback};
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= SEED;
        end else begin
            state_q <= state_d;
        end
    end

    // ----------------------------------------------------------------------
    // Way select
    // ----------------------------------------------------------------------
    // Low bits of the current state, before any step at this edge
    assign refill_way_bin = state_q[$clog2(WIDTH)-1:0];

    always_comb begin
        refill_way_oh = '0;
        refill_way_oh[refill_way_bin] = 1'b1;
    end

    // Way number is taken from the 16 state bits
    initial begin
        assert (WIDTH <= 16)
            else $fatal(1, "lfsr_16bit: WIDTH must not exceed 16");
    end

endmodule

`default_nettype wire

// File: rtl/tag_lookup.sv
// Tag store with one-cycle lookup, reports hit or miss and pushes misses to the queue
`default_nettype none

module tag_lookup import cache_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    // Lookup request
    input  logic                req_valid,
    input  logic [ADDR_W-1:0]   req_addr,
    // Lookup result, one cycle after the strobe
    output logic                hit,
    output logic [WAY_W-1:0]    hit_way,
    output logic                miss,
    // Miss path to the queue
    miss_if.tag_lookup          miss_port,
    // Write port from the refill unit
    input  logic                tag_we,
    input  logic [INDEX_W-1:0]  tag_set,
    input  logic [NUM_WAYS-1:0] tag_way_oh,
    input  logic [TAG_W-1:0]    tag_tag
);

    // ----------------------------------------------------------------------
    // Tag store
    // ----------------------------------------------------------------------
    // Valid bits are control state and clear on reset
    logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
    logic [TAG_W-1:0]                  tag_q [NUM_SETS][NUM_WAYS];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (tag_we) begin
            valid_q[tag_set] <= valid_q[tag_set] | tag_way_oh;
        end
    end

    // Tag bits only change on a refill write
    always_ff @(posedge clk_i) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (tag_we && tag_way_oh[w]) begin
                tag_q[tag_set][w] <= tag_tag;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Compare
    // ----------------------------------------------------------------------
    logic [INDEX_W-1:0]  req_index;
    logic [TAG_W-1:0]    req_tag;
    tag_entry_t          set_entries [NUM_WAYS];
    logic [NUM_WAYS-1:0] match;
    logic [WAY_W-1:0]    match_way;
    logic                hit_any;

    assign req_index = req_addr[OFFSET_W +: INDEX_W];
    assign req_tag   = req_addr[ADDR_W-1 -: TAG_W];

    // All ways of the indexed set in parallel, store as it stood before this edge
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            set_entries[w].valid = valid_q[req_index][w];
            set_entries[w].tag   = tag_q[req_index][w];
            match[w] = set_entries[w].valid && (set_entries[w].tag == req_tag);
        end
    end

    // Lowest matching way wins, scan downward so the last write is the lowest
    always_comb begin
        match_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                match_way = WAY_W'(w);
            end
        end
    end

    assign hit_any = |match;

    // ----------------------------------------------------------------------
    // Result registers
    // ----------------------------------------------------------------------
    logic             hit_q;
    logic             miss_q;
    logic [WAY_W-1:0] hit_way_q;
    miss_entry_t      entry_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            hit_q     <= 1'b0;
            miss_q    <= 1'b0;
            hit_way_q <= '0;
        end else begin
            hit_q     <= req_valid && hit_any;
            miss_q    <= req_valid && !hit_any;
            hit_way_q <= match_way;
        end
    end

    // Missed line captured alongside the result
    always_ff @(posedge clk_i) begin
        if (req_valid) begin
            entry_q.index <= req_index;
            entry_q.tag   <= req_tag;
        end
    end

    assign hit     = hit_q;
    assign hit_way = hit_way_q;
    assign miss    = miss_q;

    // Miss pushes in the same cycle it is reported, enters the queue next edge
    assign miss_port.push  = miss_q;
    assign miss_port.entry = entry_q;

    // Caller back-pressure must keep the queue from overflowing
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        miss_port.push |-> !miss_port.full)
        else $error("tag_lookup: miss pushed while queue full");

endmodule

`default_nettype wire

// File: rtl/miss_fifo.sv
// Circular queue of outstanding misses, pushed through miss_if and popped by the refill unit
`default_nettype none

module miss_fifo import cache_pkg::*; #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    // Push side with full level
    miss_if.miss_fifo in_port,
    // Pop side
    input  logic     pop,
    output logic     empty,
    output payload_t head
);

    // ----------------------------------------------------------------------
    // Storage and pointers
    // ----------------------------------------------------------------------
    payload_t              mem_q [MISS_DEPTH];
    logic [MISS_PTR_W-1:0] wr_ptr_q;
    logic [MISS_PTR_W-1:0] rd_ptr_q;
    logic [MISS_CNT_W-1:0] count_q;

    // Entry storage holds payload only
    always_ff @(posedge clk_i) begin
        if (in_port.push) begin
            mem_q[wr_ptr_q] <= in_port.entry;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // Pointers wrap at the last slot, depth need not be a power of two
            if (in_port.push) begin
                if (wr_ptr_q == MISS_PTR_W'(MISS_DEPTH - 1)) begin
                    wr_ptr_q <= '0;
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr_q == MISS_PTR_W'(MISS_DEPTH - 1)) begin
                    rd_ptr_q <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end
            // Occupancy
            case ({in_port.push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Levels and head
    // ----------------------------------------------------------------------
    assign empty        = (count_q == '0);
    assign in_port.full = (count_q == MISS_CNT_W'(MISS_DEPTH));
    // Oldest entry, valid while empty is low
    assign head         = mem_q[rd_ptr_q];

    // Producer is the lookup stage, it must respect full
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        in_port.push |-> !in_port.full)
        else $error("miss_fifo: push while full");

    // Refill unit only pops a queue that holds an entry
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop |-> !empty)
        else $error("miss_fifo: pop while empty");

endmodule

`default_nettype wire

// File: rtl/refill_unit.sv
// Refill controller that drains the miss queue and writes each tag into the LFSR-chosen way
`default_nettype none

module refill_unit import cache_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    // Miss queue side
    input  logic                empty,
    input  miss_entry_t         head,
    output logic                pop,
    // Tag store write port
    output logic                tag_we,
    output logic [INDEX_W-1:0]  tag_set,
    output logic [NUM_WAYS-1:0] tag_way_oh,
    output logic [TAG_W-1:0]    tag_tag,
    // Refill report
    output logic                refill_valid,
    output logic [WAY_W-1:0]    refill_way
);

    // ----------------------------------------------------------------------
    // Controller
    // ----------------------------------------------------------------------
    typedef enum logic {
        IDLE,
        WRITE
    } state_e;

    state_e      state_q;
    state_e      state_d;
    miss_entry_t entry_q;

    // Pop when idle and the queue holds something
    assign pop = (state_q == IDLE) && !empty;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (!empty) begin
                    state_d = WRITE;
                end
            end
            // Write lasts exactly one cycle
            WRITE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Head is captured on the pop edge before the queue moves on
    always_ff @(posedge clk_i) begin
        if (pop) begin
            entry_q <= head;
        end
    end

    // ----------------------------------------------------------------------
    // Victim selection and write
    // ----------------------------------------------------------------------
    logic [NUM_WAYS-1:0] victim_oh;
    logic [WAY_W-1:0]    victim_bin;

    // Steps on the write edge so this write uses the state before the step
    lfsr_16bit #(
        .SEED  (LFSR_SEED),
        .WIDTH (NUM_WAYS)
    ) i_lfsr (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .en             (tag_we),
        .refill_way_oh  (victim_oh),
        .refill_way_bin (victim_bin)
    );

    assign tag_we       = (state_q == WRITE);
    assign tag_set      = entry_q.index;
    assign tag_tag      = entry_q.tag;
    assign tag_way_oh   = victim_oh;
    // Report pulse coincides with the store write
    assign refill_valid = tag_we;
    assign refill_way   = victim_bin;

    // Popped entry was written into the queue before
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop |-> !$isunknown(head))
        else $error("refill_unit: pop of an unwritten queue entry");

endmodule

`default_nettype wire

// File: rtl/cache_tag_top.sv
// Top level of the cache tag subsystem, lookup, miss queue and refill on plain ports
`default_nettype none

module cache_tag_top import cache_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,
    // Lookup request and result
    input  logic               req_valid,
    input  logic [ADDR_W-1:0]  req_addr,
    output logic               hit,
    output logic [WAY_W-1:0]   hit_way,
    output logic               miss,
    // Caller holds off requests while high
    output logic               miss_full,
    // Refill completion
    output logic               refill_valid,
    output logic [INDEX_W-1:0] refill_set,
    output logic [WAY_W-1:0]   refill_way
);

    // ----------------------------------------------------------------------
    // Internal wiring
    // ----------------------------------------------------------------------
    miss_if miss_bus ();

    logic                fifo_empty;
    miss_entry_t         fifo_head;
    logic                fifo_pop;
    logic                tag_we;
    logic [INDEX_W-1:0]  tag_set;
    logic [NUM_WAYS-1:0] tag_way_oh;
    logic [TAG_W-1:0]    tag_tag;

    assign miss_full  = miss_bus.full;
    assign refill_set = tag_set;

    tag_lookup i_lookup (
        .clk_i (clk_i), .rst_ni (rst_ni),
        .req_valid (req_valid), .req_addr (req_addr),
        .hit (hit), .hit_way (hit_way), .miss (miss),
        .miss_port (miss_bus.tag_lookup),
        .tag_we (tag_we), .tag_set (tag_set),
        .tag_way_oh (tag_way_oh), .tag_tag (tag_tag)
    );

    // Queue payload is the miss entry
    miss_fifo #(
        .payload_t (miss_entry_t)
    ) i_fifo (
        .clk_i (clk_i), .rst_ni (rst_ni),
        .in_port (miss_bus.miss_fifo),
        .pop (fifo_pop), .empty (fifo_empty), .head (fifo_head)
    );

    refill_unit i_refill (
        .clk_i (clk_i), .rst_ni (rst_ni),
        .empty (fifo_empty), .head (fifo_head), .pop (fifo_pop),
        .tag_we (tag_we), .tag_set (tag_set),
        .tag_way_oh (tag_way_oh), .tag_tag (tag_tag),
        .refill_valid (refill_valid), .refill_way (refill_way)
    );

endmodule

`default_nettype wire

// File: verification/tb_cache_tag.sv
// Testbench for the cache tag subsystem that checks lookups and refills against a reference model
`default_nettype none

module tb_cache_tag import cache_pkg::*; ();

    localparam int TIMEOUT   = 200;
    localparam int BURST_MAX = 40;

    logic               clk_i;
    logic               rst_ni;
    logic               req_valid;
    logic [ADDR_W-1:0]  req_addr;
    logic               hit;
    logic [WAY_W-1:0]   hit_way;
    logic               miss;
    logic               miss_full;
    logic               refill_valid;
    logic [INDEX_W-1:0] refill_set;
    logic [WAY_W-1:0]   refill_way;

    int errors;
    int tests_run;
    int tests_failed;

    // Reference model of the tag store and the replacement LFSR
    logic             mdl_valid [NUM_SETS][NUM_WAYS];
    logic [TAG_W-1:0] mdl_tag [NUM_SETS][NUM_WAYS];
    logic [15:0]      mdl_lfsr;

    // Refill pulses seen on the DUT, in arrival order
    logic [INDEX_W-1:0] seen_set_q [$];
    logic [WAY_W-1:0]   seen_way_q [$];
    logic [ADDR_W-1:0]  issued_q [$];

    // Data file contents
    int                f_test [$];
    logic [ADDR_W-1:0] f_addr [$];
    int                f_flag [$];

    cache_tag_top dut (
        .clk_i (clk_i), .rst_ni (rst_ni),
        .req_valid (req_valid), .req_addr (req_addr),
        .hit (hit), .hit_way (hit_way), .miss (miss), .miss_full (miss_full),
        .refill_valid (refill_valid), .refill_set (refill_set), .refill_way (refill_way)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // Refill monitor samples at the falling edge where outputs are stable
    always @(negedge clk_i) begin
        if (rst_ni && refill_valid) begin
            seen_set_q.push_back(refill_set);
            seen_way_q.push_back(refill_way);
        end
    end

    // ----------------------------------------------------------------------
    // Model and check helpers
    // ----------------------------------------------------------------------
    function automatic bit model_hit(input logic [ADDR_W-1:0] addr, output logic [WAY_W-1:0] way);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tg;
        bit                 found;
        idx   = addr[OFFSET_W +: INDEX_W];
        tg    = addr[ADDR_W-1 -: TAG_W];
        found = 1'b0;
        way   = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (!found && mdl_valid[idx][w] && mdl_tag[idx][w] == tg) begin
                found = 1'b1;
                way   = WAY_W'(w);
            end
        end
        return found;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("Run stopped at t=%0t: %s", $time, what);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic wait_not_full();
        int cnt;
        cnt = 0;
        @(negedge clk_i);
        while (miss_full && cnt < TIMEOUT) begin
            @(negedge clk_i);
            cnt++;
        end
        if (miss_full) abort_run("miss_full stayed high, request could not be sent");
    endtask

    // Takes the next refill pulse, checks it and applies it to the model
    task automatic expect_refill(input logic [ADDR_W-1:0] addr);
        int                 cnt;
        logic [INDEX_W-1:0] idx;
        logic [INDEX_W-1:0] got_set;
        logic [WAY_W-1:0]   got_way;
        logic [WAY_W-1:0]   mdl_way;
        cnt = 0;
        while (seen_set_q.size() == 0 && cnt < TIMEOUT) begin
            @(negedge clk_i);
            cnt++;
        end
        if (seen_set_q.size() == 0) abort_run("no refill_valid pulse arrived for a miss");
        idx     = addr[OFFSET_W +: INDEX_W];
        got_set = seen_set_q.pop_front();
        got_way = seen_way_q.pop_front();
        mdl_way = mdl_lfsr[WAY_W-1:0];
        check_val("refill_set", idx, got_set);
        check_val("refill_way", mdl_way, got_way);
        mdl_valid[idx][mdl_way] = 1'b1;
        mdl_tag[idx][mdl_way]   = addr[ADDR_W-1 -: TAG_W];
        mdl_lfsr = {mdl_lfsr[14:0], ~(mdl_lfsr[15] ^ mdl_lfsr[12] ^ mdl_lfsr[5] ^ mdl_lfsr[1])};
    endtask

    // One strobe with the result checked one cycle after the sampling edge
    task automatic lookup_and_refill(input logic [ADDR_W-1:0] addr, input int flag);
        bit               exp_hit;
        logic [WAY_W-1:0] exp_way;
        wait_not_full();
        @(posedge clk_i);
        req_valid <= 1'b1;
        req_addr  <= addr;
        @(posedge clk_i);
        req_valid <= 1'b0;
        @(negedge clk_i);
        exp_hit = model_hit(addr, exp_way);
        check_val("hit", exp_hit, hit);
        check_val("miss", !exp_hit, miss);
        if (exp_hit) check_val("hit_way", exp_way, hit_way);
        if (flag >= 0) check_val("hit (data file flag)", flag, hit);
        if (!exp_hit) expect_refill(addr);
    endtask

    task automatic run_file_test(input int n);
        foreach (f_test[i]) begin
            if (f_test[i] == n) lookup_and_refill(f_addr[i], f_flag[i]);
        end
    endtask

    task automatic end_test(input int n, input string name, input int err_before);
        if (seen_set_q.size() != 0) begin
            $display("Unexpected refill_valid pulse left over after test %0d", n);
            errors++;
            seen_set_q.delete();
            seen_way_q.delete();
        end
        tests_run++;
        if (errors == err_before) begin
            $display("test %0d %s: passed", n, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL with %0d errors", n, name, errors - err_before);
        end
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin
        int                fd;
        int                got;
        int                t;
        int                f;
        int                e0;
        int                issued;
        int                gap;
        int                cyc;
        bit                drove;
        bit                due;
        bit                pair;
        bit                saw_full;
        bit                go;
        logic [WAY_W-1:0]  unused_way;
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] drove_addr;
        logic [ADDR_W-1:0] due_addr;
        string             line;

        rst_ni    = 1'b0;
        req_valid = 1'b0;
        req_addr  = '0;
        errors    = 0;
        tests_run = 0;
        tests_failed = 0;
        void'($urandom(32'h3777_16db));
        for (int s = 0; s < NUM_SETS; s++) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                mdl_valid[s][w] = 1'b0;
                mdl_tag[s][w]   = '0;
            end
        end
        mdl_lfsr = LFSR_SEED;

        fd = $fopen("verification/lookup_input.txt", "r");
        if (fd == 0) abort_run("data file verification/lookup_input.txt could not be opened");
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            if (got > 0 && line.len() > 0 && line[0] != "#") begin
                if ($sscanf(line, "%d %h %d", t, a, f) == 3) begin
                    f_test.push_back(t);
                    f_addr.push_back(a);
                    f_flag.push_back(f);
                end
            end
        end
        $fclose(fd);

        repeat (8) @(posedge clk_i);
        rst_ni <= 1'b1;

        // Quiet outputs after reset and then cold misses
        e0 = errors;
        repeat (4) begin
            @(negedge clk_i);
            check_val("hit", 0, hit);
            check_val("miss", 0, miss);
            check_val("refill_valid", 0, refill_valid);
            check_val("miss_full", 0, miss_full);
        end
        run_file_test(1);
        end_test(1, "after reset", e0);

        e0 = errors;
        run_file_test(2);
        end_test(2, "miss refill hit", e0);

        // Six lines into set 3 and a revisit of all of them
        e0 = errors;
        for (int k = 0; k < 6; k++) lookup_and_refill({TAG_W'(24'h300000 + k), 4'h3, 4'h0}, -1);
        for (int k = 0; k < 6; k++) lookup_and_refill({TAG_W'(24'h300000 + k), 4'h3, 4'h0}, -1);
        end_test(3, "replacement sequence", e0);

        // Burst of fresh lines over sets 8 to 11
        // At most two requests in a row so that lookups still in flight fit the queue
        e0 = errors;
        issued = 0;
        gap = 0;
        cyc = 0;
        drove = 1'b0;
        due = 1'b0;
        saw_full = 1'b0;
        drove_addr = '0;
        while (((issued < BURST_MAX && !saw_full) || drove || due) && cyc < TIMEOUT) begin
            @(negedge clk_i);
            cyc++;
            if (due) begin
                check_val("miss", !model_hit(due_addr, unused_way), miss);
            end
            pair     = due && drove;
            due      = drove;
            due_addr = drove_addr;
            if (miss_full) saw_full = 1'b1;
            go = (issued < BURST_MAX) && !saw_full && !pair && (gap == 0);
            a  = {TAG_W'(24'hB00000 + issued), INDEX_W'(8 + issued % 4), 4'h0};
            @(posedge clk_i);
            if (go) begin
                req_valid  <= 1'b1;
                req_addr   <= a;
                issued_q.push_back(a);
                issued++;
                gap        = ($urandom % 8 == 0) ? 1 : 0;
                drove      = 1'b1;
                drove_addr = a;
            end else begin
                req_valid <= 1'b0;
                drove     = 1'b0;
                if (gap > 0) gap--;
            end
        end
        if (cyc >= TIMEOUT) abort_run("burst of requests did not complete");
        if (!saw_full) begin
            $display("miss_full never rose during the burst of %0d requests", issued);
            errors++;
        end
        while (issued_q.size() > 0) expect_refill(issued_q.pop_front());
        end_test(4, "burst and back-pressure", e0);

        e0 = errors;
        run_file_test(5);
        end_test(5, "data file hit flags", e0);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/lookup_input.txt
# Columns: test number, request address (hex), expected hit flag (1 hit, 0 miss)
# Set index is address bits 7:4, tag is bits 31:8
1 00000000 0
1 00ABC0F0 0
2 12345610 0
2 12345610 1
2 1234561C 1
2 12345610 1
5 DEAD0040 0
5 DEAD0040 1
5 DEAD004F 1
5 BEEF0050 0
5 BEEF0058 1
5 DEAD0044 1
5 0C0FFE60 0
5 0C0FFE60 1
5 111111C0 0
5 111111C8 1
5 222222D0 0
5 222222D4 1
5 BEEF0050 1
5 0C0FFE6C 1
5 00ABC0F4 1
5 12345610 1
5 00000008 1

// File: all.f
rtl/cache_pkg.sv
rtl/miss_if.sv
rtl/lfsr_16bit.sv
rtl/tag_lookup.sv
rtl/miss_fifo.sv
rtl/refill_unit.sv
rtl/cache_tag_top.sv
verification/tb_cache_tag.sv
